// File: sources.f
+incdir+include
source/fir_pkg.sv
source/fir_coef_bank.sv
source/fir_tail_delay.sv
source/fir_systolic_element.sv
source/fir_round_sat.sv
source/fir_symmetric_systolic_top.sv
testbench/tb_fir_top.sv

// File: testbench/tb_fir_top.sv
`default_nettype none

`include "fir_settings.svh"

module tb_fir_top
    import fir_pkg::*;
();

    localparam int T           = `FIR_TAP_NUM;
    localparam int TAPS        = 2 * T;
    localparam int DEPTH       = T + 2;   // strobes from an input sample to its first output term.
    localparam int HIST_LEN    = DEPTH + TAPS;
    localparam int FLUSH_LEN   = 3 * T + 4;
    localparam int MAX_ROWS    = 16;
    localparam int DRAIN_LIMIT = 200;
    localparam int SHIFT       = `FIR_OUT_SHIFT;

    localparam longint HALF    = longint'(1) <<< (SHIFT - 1);
    localparam longint OUT_MAX = (longint'(1) <<< (`FIR_DATA_WIDTH - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) <<< (`FIR_DATA_WIDTH - 1));

    localparam int KIND_IMPULSE = 0;
    localparam int KIND_STEP    = 1;
    localparam int KIND_FULL    = 2;
    localparam int KIND_TIE     = 3;
    localparam int KIND_RANDOM  = 4;

    logic       clk_i;
    logic       rst_n_i;
    logic       coef_we_i;
    coef_addr_t coef_addr_i;
    coef_t      coef_data_i;
    logic       sample_valid_i;
    sample_t    sample_i;
    logic       odd_even_i;
    logic       out_valid_o;
    sample_t    out_o;
    logic       sat_o;

    // each array holds one field of the stimulus table, indexed by row.
    int row_set   [MAX_ROWS];
    int row_mode  [MAX_ROWS];
    int row_kind  [MAX_ROWS];
    int row_amp   [MAX_ROWS];
    int row_count [MAX_ROWS];
    int row_gap   [MAX_ROWS];
    int num_rows;

    longint      hist       [HIST_LEN];  // hist[m] holds the sample m strobes back.
    longint      model_coef [T];
    logic        model_odd;
    longint      exp_out_q  [$];
    longint      exp_sat_q  [$];
    logic [31:0] lcg_state;
    int          tie_count;
    int          sat_count;
    logic        valid_seen;

    fir_symmetric_systolic_top dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .coef_we_i     (coef_we_i),
        .coef_addr_i   (coef_addr_i),
        .coef_data_i   (coef_data_i),
        .sample_valid_i(sample_valid_i),
        .sample_i      (sample_i),
        .odd_even_i    (odd_even_i),
        .out_valid_o   (out_valid_o),
        .out_o         (out_o),
        .sat_o         (sat_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            $display("ERR time=%0t signal=%s actual=%0d expected=%0d",
                     $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic coef_t coef_value(input int set, input int i);
        case (set)
            0:       return coef_t'(2500 * (i + 1) - 6000);
            1:       return (i == 0) ? coef_t'(16384) : coef_t'(0);  // 0.5 on the outer pair only.
            2:       return coef_t'(32767 - 1000 * i);
            3:       return coef_t'((i * 7919 + 1234) % 65536 - 32768);
            default: return (i % 2 == 1) ? coef_t'(-4096) : coef_t'(8192 / (i + 1));
        endcase
    endfunction

    // odd magnitudes on even indices, so mirrored pairs 2T-1 apart sum to an odd value.
    function automatic longint tie_sample(input int n);
        longint mag;
        mag = (n % 2 == 1) ? 2 * n + 2 : 2 * n + 1;
        return (n % 4 >= 2) ? -mag : mag;
    endfunction

    function automatic longint stim_sample(input int kind, input int amp, input int n,
                                           input int count);
        case (kind)
            KIND_IMPULSE: return (n == 0) ? longint'(amp) : 0;
            KIND_STEP:    return longint'(amp);
            KIND_FULL:    return (n < count / 2) ? OUT_MAX : OUT_MIN;
            default:      return tie_sample(n);
        endcase
    endfunction

    task automatic add_row(input int set, input int mode, input int kind, input int amp,
                           input int count, input int gap);
        row_set[num_rows]   = set;
        row_mode[num_rows]  = mode;
        row_kind[num_rows]  = kind;
        row_amp[num_rows]   = amp;
        row_count[num_rows] = count;
        row_gap[num_rows]   = gap;
        num_rows++;
    endtask

    task automatic build_table();
        add_row(0, 0, KIND_IMPULSE, 32767, 4, 0);
        add_row(4, 1, KIND_IMPULSE, -32768, 3, 2);
        add_row(0, 0, KIND_STEP, 10000, 30, 1);
        add_row(1, 0, KIND_TIE, 0, 40, 0);
        add_row(1, 1, KIND_TIE, 0, 40, 0);
        add_row(2, 0, KIND_FULL, 0, 40, 0);
        add_row(2, 1, KIND_STEP, -32768, 30, 3);
        add_row(3, 0, KIND_RANDOM, 0, 200, 3);
        add_row(3, 1, KIND_RANDOM, 0, 200, 0);
        add_row(0, 1, KIND_RANDOM, 0, 100, 5);
    endtask

    task automatic model_step(input longint x, output longint y, output logic sat);
        longint acc;
        longint cj;
        longint fl;
        longint rem;
        for (int m = HIST_LEN - 1; m > 0; m--) begin
            hist[m] = hist[m-1];
        end
        hist[0] = x;
        acc = 0;
        for (int j = 0; j < TAPS; j++) begin
            if (j < T) begin
                cj = model_coef[j];
            end else begin
                cj = model_coef[TAPS-1-j];  // mirrored half of the impulse response.
            end
            acc += cj * hist[DEPTH + j];
        end
        fl  = acc >>> SHIFT;
        rem = acc - (fl <<< SHIFT);
        if (rem > HALF) begin
            y = fl + 1;
        end else if (rem < HALF) begin
            y = fl;
        end else begin
            tie_count++;
            y = (fl[0] == model_odd) ? fl : fl + 1;
        end
        sat = 1'b0;
        if (y > OUT_MAX) begin
            y   = OUT_MAX;
            sat = 1'b1;
        end else if (y < OUT_MIN) begin
            y   = OUT_MIN;
            sat = 1'b1;
        end
        if (sat) begin
            sat_count++;
        end
    endtask

    task automatic load_coefs(input int set);
        for (int i = 0; i < T; i++) begin
            @(posedge clk_i);
            coef_we_i     <= 1'b1;
            coef_addr_i   <= coef_addr_t'(i);
            coef_data_i   <= coef_value(set, i);
            model_coef[i] = coef_value(set, i);
        end
        @(posedge clk_i);
        coef_we_i <= 1'b0;
    endtask

    task automatic drive_sample(input longint x, input int gap);
        longint y;
        logic   sat;
        @(posedge clk_i);
        sample_valid_i <= 1'b1;
        sample_i       <= sample_t'(x);
        model_step(x, y, sat);
        exp_out_q.push_back(y);
        exp_sat_q.push_back(longint'(sat));
        repeat (gap) begin
            @(posedge clk_i);
            sample_valid_i <= 1'b0;
        end
    endtask

    task automatic idle_input();
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_out_q.size() != 0) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                fail_run("timeout waiting for out_valid_o, results still pending");
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] rnd;
        sample_t     s;
        longint      x;
        int          gap;
        load_coefs(row_set[r]);
        odd_even_i <= (row_mode[r] != 0);
        model_odd  = (row_mode[r] != 0);
        for (int n = 0; n < row_count[r]; n++) begin
            if (row_kind[r] == KIND_RANDOM) begin
                rnd = lcg_next();
                s   = rnd[31:16];
                x   = s;
                gap = int'(rnd[15:8]) % (row_gap[r] + 1);
            end else begin
                x   = stim_sample(row_kind[r], row_amp[r], n, row_count[r]);
                gap = row_gap[r];
            end
            drive_sample(x, gap);
        end
        // zeros clear every pipeline register before the bank is rewritten.
        for (int n = 0; n < FLUSH_LEN; n++) begin
            drive_sample(0, 0);
        end
        idle_input();
        wait_for_drain();
    endtask

    // out_valid_o must repeat the strobe that the previous rising edge sampled.
    initial begin
        valid_seen = 1'b0;
        forever begin
            @(negedge clk_i);
            check_value("out_valid_o", longint'(out_valid_o), longint'(valid_seen));
            if (out_valid_o) begin
                if (exp_out_q.size() == 0) begin
                    fail_run("out_valid_o strobed with no sample pending");
                end
                check_value("out_o", longint'(out_o), exp_out_q.pop_front());
                check_value("sat_o", longint'(sat_o), exp_sat_q.pop_front());
            end
            valid_seen = sample_valid_i;
        end
    end

    initial begin
        rst_n_i        = 1'b0;
        coef_we_i      = 1'b0;
        coef_addr_i    = '0;
        coef_data_i    = '0;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        odd_even_i     = 1'b0;
        lcg_state      = 32'h9ca0;
        tie_count      = 0;
        sat_count      = 0;
        num_rows       = 0;
        model_odd      = 1'b0;
        for (int m = 0; m < HIST_LEN; m++) begin
            hist[m] = 0;
        end
        for (int i = 0; i < T; i++) begin
            model_coef[i] = 0;
        end
        build_table();
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (4) begin
            @(negedge clk_i);
            check_value("out_valid_o", longint'(out_valid_o), 0);
            check_value("sat_o", longint'(sat_o), 0);
            check_value("out_o", longint'(out_o), 0);
        end
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        if (tie_count == 0) begin
            fail_run("no rounding tie reached the output stage");
        end else if (sat_count == 0) begin
            fail_run("no output reached the saturation limits");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: source/fir_symmetric_systolic_top.sv
`default_nettype none

`include "fir_settings.svh"

module fir_symmetric_systolic_top
    import fir_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       coef_we_i,
    input  coef_addr_t coef_addr_i,
    input  coef_t      coef_data_i,
    input  logic       sample_valid_i,
    input  sample_t    sample_i,
    input  logic       odd_even_i,
    output logic       out_valid_o,
    output sample_t    out_o,
    output logic       sat_o
);

    coef_t   coef       [`FIR_TAP_NUM];
    sample_t chain_data [`FIR_TAP_NUM];
    acc_t    chain_casc [`FIR_TAP_NUM];
    sample_t tail_sample;

    fir_coef_bank u_coef_bank (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .we_i   (coef_we_i),
        .addr_i (coef_addr_i),
        .data_i (coef_data_i),
        .coef_o (coef)
    );

    // element 0 pre-adds the raw input sample, so the mirrored operand needs
    // one register less than the two per element on the near chain.
    fir_tail_delay #(
        .DEPTH(2 * `FIR_TAP_NUM - 1)
    ) u_tail_delay (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (sample_valid_i),
        .data_i (sample_i),
        .data_o (tail_sample)
    );

    for (genvar i = 0; i < `FIR_TAP_NUM; i++) begin : g_element
        if (i == 0) begin : g_first
            fir_systolic_element u_element (
                .clk_i     (clk_i),
                .rst_n_i   (rst_n_i),
                .en_i      (sample_valid_i),
                .coef_i    (coef[i]),
                .data_i    (sample_i),
                .dataz_i   (tail_sample),
                .casc_i    ('0),
                .cascdata_o(chain_data[i]),
                .casc_o    (chain_casc[i])
            );
        end else begin : g_next
            fir_systolic_element u_element (
                .clk_i     (clk_i),
                .rst_n_i   (rst_n_i),
                .en_i      (sample_valid_i),
                .coef_i    (coef[i]),
                .data_i    (chain_data[i-1]),
                .dataz_i   (tail_sample),
                .casc_i    (chain_casc[i-1]),
                .cascdata_o(chain_data[i]),
                .casc_o    (chain_casc[i])
            );
        end
    end

    // the last element's data chain output has no consumer.
    fir_round_sat u_round_sat (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (sample_valid_i),
        .odd_even_i (odd_even_i),
        .acc_i      (chain_casc[`FIR_TAP_NUM-1]),
        .out_o      (out_o),
        .sat_o      (sat_o),
        .out_valid_o(out_valid_o)
    );

endmodule

`default_nettype wire

// File: source/fir_round_sat.sv
`default_nettype none

`include "fir_settings.svh"

module fir_round_sat
    import fir_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    en_i,
    input  logic    odd_even_i,
    input  acc_t    acc_i,
    output sample_t out_o,
    output logic    sat_o,
    output logic    out_valid_o
);

    localparam int RND_WIDTH = ACC_WIDTH - `FIR_OUT_SHIFT + 1;

    localparam logic [`FIR_OUT_SHIFT-1:0] HALF = {1'b1, {(`FIR_OUT_SHIFT - 1){1'b0}}};

    localparam sample_t SAMPLE_MAX = {1'b0, {(`FIR_DATA_WIDTH - 1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(`FIR_DATA_WIDTH - 1){1'b0}}};

    logic signed [RND_WIDTH-1:0] trunc;
    logic signed [RND_WIDTH-1:0] rounded;
    logic [`FIR_OUT_SHIFT-1:0]   frac;
    logic                        round_up;
    logic                        sat_hi;
    logic                        sat_lo;
    sample_t                     out_next;

    // arithmetic shift floors, so frac is always the positive remainder.
    assign trunc = RND_WIDTH'(acc_i >>> `FIR_OUT_SHIFT);
    assign frac  = acc_i[`FIR_OUT_SHIFT-1:0];

    // on an exact half the parity of the floor decides the direction.
    // odd_even_i low gives an even result and high gives an odd one.
    assign round_up = (frac > HALF) || ((frac == HALF) && (trunc[0] ^ odd_even_i));

    assign rounded = trunc + {{(RND_WIDTH - 1){1'b0}}, round_up};  // extra bit absorbs the carry.

    assign sat_hi = rounded > SAMPLE_MAX;
    assign sat_lo = rounded < SAMPLE_MIN;

    always_comb begin
        if (sat_hi) begin
            out_next = SAMPLE_MAX;
        end else if (sat_lo) begin
            out_next = SAMPLE_MIN;
        end else begin
            out_next = rounded[`FIR_DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_o       <= '0;
            sat_o       <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= en_i;  // one strobe out for each strobe in.
            if (en_i) begin
                out_o <= out_next;
                sat_o <= sat_hi || sat_lo;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fir_systolic_element.sv
`default_nettype none

`include "fir_settings.svh"

module fir_systolic_element
    import fir_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    en_i,
    input  coef_t   coef_i,
    input  sample_t data_i,
    input  sample_t dataz_i,
    input  acc_t    casc_i,
    output sample_t cascdata_o,
    output acc_t    casc_o
);

    sample_t data_d1;
    sample_t data_d2;
    preadd_t preadd;
    prod_t   prod;
    acc_t    casc;

    // two registers per element on the near chain.
    // The mirrored operand moves one sample per element in the other direction.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_d1 <= '0;
            data_d2 <= '0;
        end else if (en_i) begin
            data_d1 <= data_i;
            data_d2 <= data_d1;
        end
    end

    // both taps of a symmetric pair share one coefficient.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            preadd <= '0;
        end else if (en_i) begin
            preadd <= preadd_t'(data_i) + preadd_t'(dataz_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod <= '0;
        end else if (en_i) begin
            prod <= preadd * coef_i;  // signed, full precision.
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            casc <= '0;
        end else if (en_i) begin
            casc <= acc_t'(prod) + casc_i;
        end
    end

    assign cascdata_o = data_d2;
    assign casc_o     = casc;

endmodule

`default_nettype wire

// File: source/fir_tail_delay.sv
`default_nettype none

`include "fir_settings.svh"

module fir_tail_delay
    import fir_pkg::*;
#(
    parameter int DEPTH = 2 * `FIR_TAP_NUM - 1
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    en_i,
    input  sample_t data_i,
    output sample_t data_o
);

    sample_t stage [DEPTH];

    // the line only moves on a sample strobe, so its delay is counted in samples.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (en_i) begin
            stage[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign data_o = stage[DEPTH-1];  // oldest sample held in the line.

endmodule

`default_nettype wire

// File: source/fir_coef_bank.sv
`default_nettype none

`include "fir_settings.svh"

module fir_coef_bank
    import fir_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       we_i,
    input  coef_addr_t addr_i,
    input  coef_t      data_i,
    output coef_t      coef_o [`FIR_TAP_NUM]
);

    logic [`FIR_TAP_NUM-1:0] wr_sel;
    coef_t                   bank [`FIR_TAP_NUM];

    // one select line per entry. An address past the last tap matches no line.
    always_comb begin
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            wr_sel[i] = we_i && (addr_i == coef_addr_t'(i));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `FIR_TAP_NUM; i++) begin
                bank[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FIR_TAP_NUM; i++) begin
                if (wr_sel[i]) begin
                    bank[i] <= data_i;  // new value is seen by the elements next cycle.
                end
            end
        end
    end

    assign coef_o = bank;

endmodule

`default_nettype wire

// File: source/fir_pkg.sv
`default_nettype none

`include "fir_settings.svh"

package fir_pkg;

    localparam int PREADD_WIDTH = `FIR_DATA_WIDTH + 1;
    localparam int PROD_WIDTH   = PREADD_WIDTH + `FIR_COEF_WIDTH;

    // the cascade grows by log2 of the element count so no partial sum can overflow.
    localparam int ACC_WIDTH    = PROD_WIDTH + $clog2(`FIR_TAP_NUM);

    localparam int COEF_ADDR_WIDTH = (`FIR_TAP_NUM > 1) ? $clog2(`FIR_TAP_NUM) : 1;

    typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
    typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;
    typedef logic signed [PREADD_WIDTH-1:0]    preadd_t;
    typedef logic signed [PROD_WIDTH-1:0]      prod_t;
    typedef logic signed [ACC_WIDTH-1:0]       acc_t;

    typedef logic [COEF_ADDR_WIDTH-1:0] coef_addr_t;

endpackage

`default_nettype wire

// File: include/fir_settings.svh
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// number of systolic elements. The filter itself has twice as many taps.
`define FIR_TAP_NUM 8

// signed sample width on input and output.
`define FIR_DATA_WIDTH 16

// coefficients are Q1.15 with the default width.
`define FIR_COEF_WIDTH 16

// fraction bits dropped by the rounding stage.
`define FIR_OUT_SHIFT (`FIR_COEF_WIDTH - 1)

`endif
